/* verilog/vmem_settings.svh */
// sizes and bit layout of the two-level virtual memory map
// the level-1 word layout is shared by the stage-2 decode and the testbench model
`ifndef VMEM_SETTINGS_SVH
`define VMEM_SETTINGS_SVH

`define VMEM0_DEPTH        2048
`define VMEM1_DEPTH        1024

`define VMA_WIDTH          24
`define VMEM0_ADDR_WIDTH   11     // vma 23:13
`define VMEM0_DATA_WIDTH   5      // block number
`define VMEM1_ADDR_WIDTH   10     // block, vma 12:8
`define VMEM1_WORD_WIDTH   24
`define PPAGE_WIDTH        14
`define PAGE_OFFSET_WIDTH  8      // vma 7:0
`define PMA_WIDTH          22
`define MAP_STATUS_WIDTH   2

// level-1 word fields
`define VMEM1_ACCESS_BIT   23
`define VMEM1_WRITE_BIT    22
`define VMEM1_STATUS_HI    21
`define VMEM1_STATUS_LO    20
`define VMEM1_PAGE_HI      13
`define VMEM1_PAGE_LO      0

`endif

/* verilog/vmem_pkg.sv */
// vector types for the map lookup path
// widths come from the settings header
`include "vmem_settings.svh"

package vmem_pkg;

   // virtual address, split 11 / 5 / 8 by the two map levels
   typedef logic [`VMA_WIDTH-1:0]          vma_t;

   typedef logic [`VMEM0_ADDR_WIDTH-1:0]   vmem0_addr_t;
   typedef logic [`VMEM0_DATA_WIDTH-1:0]   vmem0_data_t;   // block number

   typedef logic [`VMEM1_ADDR_WIDTH-1:0]   vmem1_addr_t;
   typedef logic [`VMEM1_WORD_WIDTH-1:0]   vmem1_word_t;

   typedef logic [`PPAGE_WIDTH-1:0]        ppage_t;
   typedef logic [`PAGE_OFFSET_WIDTH-1:0]  page_offset_t;

   // physical page followed by page offset
   typedef logic [`PMA_WIDTH-1:0]          pma_t;

   typedef logic [`MAP_STATUS_WIDTH-1:0]   map_status_t;

endpackage

/* verilog/vmem0_ram.sv */
// level-0 map, one block number per 8K-word region
// read and write to the same address in one cycle gives an undefined q
`timescale 1ns/1ns
`include "vmem_settings.svh"

module vmem0_ram
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  rd_en,
   input  vmem_pkg::vmem0_addr_t rd_addr,
   output vmem_pkg::vmem0_data_t q,
   input  logic                  wr_en,
   input  vmem_pkg::vmem0_addr_t wr_addr,
   input  vmem_pkg::vmem0_data_t wr_data
);

   import vmem_pkg::*;

   vmem0_data_t mem [0:`VMEM0_DEPTH-1];   // contents undefined until loaded

   // load port from the processor
   always_ff @(posedge clk_a)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // registered read, q holds when not enabled
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q <= '0;
      else if (rd_en)
         q <= mem[rd_addr];
   end

endmodule

/* verilog/vmem1_ram.sv */
// level-1 map, one 24-bit page entry per 256-word page of a block
// read and write to the same address in one cycle gives an undefined q
`timescale 1ns/1ns
`include "vmem_settings.svh"

module vmem1_ram
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  rd_en,
   input  vmem_pkg::vmem1_addr_t rd_addr,
   output vmem_pkg::vmem1_word_t q,
   input  logic                  wr_en,
   input  vmem_pkg::vmem1_addr_t wr_addr,
   input  vmem_pkg::vmem1_word_t wr_data
);

   import vmem_pkg::*;

   vmem1_word_t mem [0:`VMEM1_DEPTH-1];

   // entries written by the map-load strobe
   always_ff @(posedge clk_a)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   // q cleared by reset so the decode sees a faulting word
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q <= '0;
      else if (rd_en)
         q <= mem[rd_addr];
   end

endmodule

/* verilog/map_stage0.sv */
// first lookup stage, level-0 read straight from the request inputs
// vma and write_access are only sampled while lookup_req is high
`timescale 1ns/1ns

module map_stage0
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  lookup_req,
   input  vmem_pkg::vma_t        vma,
   input  logic                  write_access,
   input  logic                  vmem0_wr,
   input  vmem_pkg::vmem0_addr_t vmem0_wr_addr,
   input  vmem_pkg::vmem0_data_t vmem0_wr_data,
   output vmem_pkg::vmem0_data_t block,
   output logic                  s0_valid,
   output logic [12:0]           s0_vma_low,
   output logic                  s0_write
);

   import vmem_pkg::*;

   vmem0_addr_t l0_addr;

   assign l0_addr = vma[23:13];   // 8K-word region

   vmem0_ram u_vmem0_ram
   (
      .clk_a   (clk_a),
      .reset   (reset),
      .rd_en   (lookup_req),
      .rd_addr (l0_addr),
      .q       (block),
      .wr_en   (vmem0_wr),
      .wr_addr (vmem0_wr_addr),
      .wr_data (vmem0_wr_data)
   );

   always_ff @(posedge clk_a)
   begin
      if (reset)
         s0_valid <= 1'b0;
      else
         s0_valid <= lookup_req;
   end

   // travels with block, same edge as the ram read
   always_ff @(posedge clk_a)
   begin
      s0_vma_low <= vma[12:0];
      s0_write   <= write_access;
   end

endmodule

/* verilog/map_stage1.sv */
// second lookup stage, level-1 read indexed by block and vma 12:8
// block is only meaningful while s0_valid is high
`timescale 1ns/1ns

module map_stage1
(
   input  logic                       clk_a,
   input  logic                       reset,
   input  logic                       s0_valid,
   input  vmem_pkg::vmem0_data_t      block,
   input  logic [12:0]                s0_vma_low,
   input  logic                       s0_write,
   input  logic                       vmem1_wr,
   input  vmem_pkg::vmem1_addr_t      vmem1_wr_addr,
   input  vmem_pkg::vmem1_word_t      vmem1_wr_data,
   output vmem_pkg::vmem1_word_t      vmem1_q,
   output logic                       s1_valid,
   output vmem_pkg::page_offset_t     s1_offset,
   output logic                       s1_write
);

   import vmem_pkg::*;

   vmem1_addr_t l1_addr;

   // block number selects 32 pages, vma 12:8 picks one
   assign l1_addr = {block, s0_vma_low[12:8]};

   vmem1_ram u_vmem1_ram
   (
      .clk_a   (clk_a),
      .reset   (reset),
      .rd_en   (s0_valid),
      .rd_addr (l1_addr),
      .q       (vmem1_q),
      .wr_en   (vmem1_wr),
      .wr_addr (vmem1_wr_addr),
      .wr_data (vmem1_wr_data)
   );

   always_ff @(posedge clk_a)
   begin
      if (reset)
         s1_valid <= 1'b0;
      else
         s1_valid <= s0_valid;
   end

   always_ff @(posedge clk_a)
   begin
      s1_offset <= s0_vma_low[7:0];   // word within page
      s1_write  <= s0_write;
   end

endmodule

/* verilog/map_stage2.sv */
// final stage, decodes the level-1 word into pma, status and faults
// pma and map_status are only meaningful while map_valid is high
`timescale 1ns/1ns
`include "vmem_settings.svh"

module map_stage2
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   s1_valid,
   input  vmem_pkg::vmem1_word_t  vmem1_q,
   input  vmem_pkg::page_offset_t s1_offset,
   input  logic                   s1_write,
   output logic                   map_valid,
   output vmem_pkg::pma_t         pma,
   output vmem_pkg::map_status_t  map_status,
   output logic                   map_fault,
   output logic                   write_fault
);

   import vmem_pkg::*;

   ppage_t      page;
   map_status_t status;
   logic        access_ok;
   logic        write_ok;

   assign page      = vmem1_q[`VMEM1_PAGE_HI:`VMEM1_PAGE_LO];
   assign status    = vmem1_q[`VMEM1_STATUS_HI:`VMEM1_STATUS_LO];
   assign access_ok = vmem1_q[`VMEM1_ACCESS_BIT];
   assign write_ok  = vmem1_q[`VMEM1_WRITE_BIT];

   // faults pulse only alongside map_valid
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         map_valid   <= 1'b0;
         map_fault   <= 1'b0;
         write_fault <= 1'b0;
      end
      else
      begin
         map_valid   <= s1_valid;
         map_fault   <= s1_valid & ~access_ok;
         // no write fault on a page that is not mapped at all
         write_fault <= s1_valid & access_ok & s1_write & ~write_ok;
      end
   end

   always_ff @(posedge clk_a)
   begin
      pma        <= {page, s1_offset};
      map_status <= status;
   end

endmodule

/* verilog/vmem_map.sv */
// two-level map, lookup_req in one cycle gives map_valid three cycles later
// no back-pressure, a request may be issued every cycle
// a map write needs a few idle cycles before a lookup that depends on it
`timescale 1ns/1ns

module vmem_map
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  lookup_req,
   input  vmem_pkg::vma_t        vma,
   input  logic                  write_access,
   input  logic                  vmem0_wr,
   input  vmem_pkg::vmem0_addr_t vmem0_wr_addr,
   input  vmem_pkg::vmem0_data_t vmem0_wr_data,
   input  logic                  vmem1_wr,
   input  vmem_pkg::vmem1_addr_t vmem1_wr_addr,
   input  vmem_pkg::vmem1_word_t vmem1_wr_data,
   output logic                  map_valid,
   output vmem_pkg::pma_t        pma,
   output vmem_pkg::map_status_t map_status,
   output logic                  map_fault,
   output logic                  write_fault
);

   import vmem_pkg::*;

   vmem0_data_t  block;
   logic         s0_valid;
   logic [12:0]  s0_vma_low;
   logic         s0_write;
   vmem1_word_t  vmem1_q;
   logic         s1_valid;
   page_offset_t s1_offset;
   logic         s1_write;

   map_stage0 u_map_stage0
   (
      .clk_a         (clk_a),
      .reset         (reset),
      .lookup_req    (lookup_req),
      .vma           (vma),
      .write_access  (write_access),
      .vmem0_wr      (vmem0_wr),
      .vmem0_wr_addr (vmem0_wr_addr),
      .vmem0_wr_data (vmem0_wr_data),
      .block         (block),
      .s0_valid      (s0_valid),
      .s0_vma_low    (s0_vma_low),
      .s0_write      (s0_write)
   );

   map_stage1 u_map_stage1
   (
      .clk_a         (clk_a),
      .reset         (reset),
      .s0_valid      (s0_valid),
      .block         (block),
      .s0_vma_low    (s0_vma_low),
      .s0_write      (s0_write),
      .vmem1_wr      (vmem1_wr),
      .vmem1_wr_addr (vmem1_wr_addr),
      .vmem1_wr_data (vmem1_wr_data),
      .vmem1_q       (vmem1_q),
      .s1_valid      (s1_valid),
      .s1_offset     (s1_offset),
      .s1_write      (s1_write)
   );

   map_stage2 u_map_stage2
   (
      .clk_a         (clk_a),
      .reset         (reset),
      .s1_valid      (s1_valid),
      .vmem1_q       (vmem1_q),
      .s1_offset     (s1_offset),
      .s1_write      (s1_write),
      .map_valid     (map_valid),
      .pma           (pma),
      .map_status    (map_status),
      .map_fault     (map_fault),
      .write_fault   (write_fault)
   );

endmodule

/* tb/tb_clock.sv */
// clk_a at 8 ns, reset held high for the first 16 rising edges
// reset drops 1 ns after an edge, like the other testbench inputs
`timescale 1ns/1ns

module tb_clock
(
   output logic clk_a,
   output logic reset
);

   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 16;

   initial
   begin
      clk_a = 1'b0;
      forever #HALF_PERIOD clk_a = ~clk_a;
   end

   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_a);
      #1 reset = 1'b0;
   end

endmodule

/* tb/vmem_map_checker.sv */
// watches the map ports on the falling edge, when inputs and outputs are both stable
// mirrors both maps and predicts each lookup from the level-1 word layout
`timescale 1ns/1ns
`include "vmem_settings.svh"

module vmem_map_checker
(
   input  logic                  clk_a,
   input  logic                  reset,
   input  logic                  lookup_req,
   input  vmem_pkg::vma_t        vma,
   input  logic                  write_access,
   input  logic                  vmem0_wr,
   input  vmem_pkg::vmem0_addr_t vmem0_wr_addr,
   input  vmem_pkg::vmem0_data_t vmem0_wr_data,
   input  logic                  vmem1_wr,
   input  vmem_pkg::vmem1_addr_t vmem1_wr_addr,
   input  vmem_pkg::vmem1_word_t vmem1_wr_data,
   input  logic                  map_valid,
   input  vmem_pkg::pma_t        pma,
   input  vmem_pkg::map_status_t map_status,
   input  logic                  map_fault,
   input  logic                  write_fault,
   output int                    error_count,
   output int                    checked_count,
   output int                    pending,
   output int                    map_fault_count,
   output int                    write_fault_count
);

   import vmem_pkg::*;

   vmem0_data_t l0_model [0:`VMEM0_DEPTH-1];
   vmem1_word_t l1_model [0:`VMEM1_DEPTH-1];
   vma_t        req_vma [$];
   logic        req_write [$];
   int          req_cycle [$];   // falling-edge count when the request was seen
   int          cycle = 0;
   int          errors = 0;
   int          checked = 0;
   int          queued = 0;
   int          mf_seen = 0;
   int          wf_seen = 0;

   assign error_count       = errors;
   assign checked_count     = checked;
   assign pending           = queued;
   assign map_fault_count   = mf_seen;
   assign write_fault_count = wf_seen;

   // expected translation of one lookup against the mirrored maps
   function automatic void expected_result(input vma_t v, input logic wr,
                                           output pma_t e_pma, output map_status_t e_status,
                                           output logic e_mf, output logic e_wf);
      vmem0_data_t blk;
      vmem1_word_t word;
      blk      = l0_model[v[23:13]];
      word     = l1_model[{blk, v[12:8]}];
      e_pma    = {word[`VMEM1_PAGE_HI:`VMEM1_PAGE_LO], v[7:0]};
      e_status = word[`VMEM1_STATUS_HI:`VMEM1_STATUS_LO];
      e_mf     = ~word[`VMEM1_ACCESS_BIT];
      e_wf     = word[`VMEM1_ACCESS_BIT] & wr & ~word[`VMEM1_WRITE_BIT];
   endfunction

   task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      errors++;
   endtask

   task automatic check_result();
      vma_t        v;
      logic        wr;
      int          issued;
      pma_t        e_pma;
      map_status_t e_status;
      logic        e_mf;
      logic        e_wf;
      v      = req_vma.pop_front();
      wr     = req_write.pop_front();
      issued = req_cycle.pop_front();
      if (cycle - issued != 3)
      begin
         $display("map_valid for vma 0x%h came %0d cycles after its request instead of 3",
                  v, cycle - issued);
         errors++;
      end
      expected_result(v, wr, e_pma, e_status, e_mf, e_wf);
      if (pma !== e_pma)
         flag_mismatch("pma", 32'(e_pma), 32'(pma));
      if (map_status !== e_status)
         flag_mismatch("map_status", 32'(e_status), 32'(map_status));
      if (map_fault !== e_mf)
         flag_mismatch("map_fault", 32'(e_mf), 32'(map_fault));
      if (write_fault !== e_wf)
         flag_mismatch("write_fault", 32'(e_wf), 32'(write_fault));
      checked++;
      if (map_fault)
         mf_seen++;
      if (write_fault)
         wf_seen++;
   endtask

   always @(negedge clk_a)
   begin
      cycle++;
      if (reset)
      begin
         req_vma.delete();
         req_write.delete();
         req_cycle.delete();
      end
      else
      begin
         if (map_valid)
         begin
            if (req_vma.size() == 0)
            begin
               $display("map_valid at %0t ns with no lookup outstanding", $time);
               errors++;
            end
            else
               check_result();
         end
         else if (map_fault || write_fault)
         begin
            $display("fault flag high at %0t ns while map_valid is low", $time);
            errors++;
         end
         if (lookup_req)
         begin
            req_vma.push_back(vma);
            req_write.push_back(write_access);
            req_cycle.push_back(cycle);
         end
         // writes land in the RAMs at the next rising edge
         if (vmem0_wr)
            l0_model[vmem0_wr_addr] = vmem0_wr_data;
         if (vmem1_wr)
            l1_model[vmem1_wr_addr] = vmem1_wr_data;
      end
      queued = req_vma.size();
   end

endmodule

/* tb/vmem_map_tb.sv */
// drives the map 1 ns after each rising edge, stimulus from a Galois LFSR
// lookups that depend on a map write wait at least four idle cycles
`timescale 1ns/1ns
`include "vmem_settings.svh"

module vmem_map_tb;

   import vmem_pkg::*;

   localparam int RESET_LEN = 18;
   localparam int T1_LEN    = 20;
   localparam int T2_LEN    = `VMEM0_DEPTH + 4 + 64 * 6;
   localparam int T3_LEN    = 32 + 12;
   localparam int T4_LEN    = 1 + 32 + 4 + 16 * 6;
   localparam int T5_LEN    = 1 + 32 + 4 + 16 * 6;
   localparam int T6_LEN    = 16 + 4 + 16 * 6;
   localparam int TIMEOUT_CYCLES = RESET_LEN + T1_LEN + T2_LEN + T3_LEN + T4_LEN
                                   + T5_LEN + T6_LEN + 100;

   logic         clk_a;
   logic         reset;
   logic         lookup_req;
   vma_t         vma;
   logic         write_access;
   logic         vmem0_wr;
   vmem0_addr_t  vmem0_wr_addr;
   vmem0_data_t  vmem0_wr_data;
   logic         vmem1_wr;
   vmem1_addr_t  vmem1_wr_addr;
   vmem1_word_t  vmem1_wr_data;
   logic         map_valid;
   pma_t         pma;
   map_status_t  map_status;
   logic         map_fault;
   logic         write_fault;
   int           error_count;
   int           checked_count;
   int           pending;
   int           map_fault_count;
   int           write_fault_count;
   logic [31:0]  lfsr_state = 32'hfb3c8cf0;
   vmem0_data_t  l0_loaded [0:`VMEM0_DEPTH-1];   // what the testbench put in vmem0
   vmem0_addr_t  regions [0:15];
   int           cycles = 0;
   int           local_errors = 0;
   int           errors_at_start;
   int           checked_at_start;
   int           mf_at_start;
   int           wf_at_start;
   int           total_errors;

   tb_clock u_tb_clock (.clk_a(clk_a), .reset(reset));

   vmem_map u_vmem_map
   (
      .clk_a(clk_a), .reset(reset), .lookup_req(lookup_req), .vma(vma),
      .write_access(write_access), .vmem0_wr(vmem0_wr), .vmem0_wr_addr(vmem0_wr_addr),
      .vmem0_wr_data(vmem0_wr_data), .vmem1_wr(vmem1_wr), .vmem1_wr_addr(vmem1_wr_addr),
      .vmem1_wr_data(vmem1_wr_data), .map_valid(map_valid), .pma(pma),
      .map_status(map_status), .map_fault(map_fault), .write_fault(write_fault)
   );

   vmem_map_checker u_checker
   (
      .clk_a(clk_a), .reset(reset), .lookup_req(lookup_req), .vma(vma),
      .write_access(write_access), .vmem0_wr(vmem0_wr), .vmem0_wr_addr(vmem0_wr_addr),
      .vmem0_wr_data(vmem0_wr_data), .vmem1_wr(vmem1_wr), .vmem1_wr_addr(vmem1_wr_addr),
      .vmem1_wr_data(vmem1_wr_data), .map_valid(map_valid), .pma(pma),
      .map_status(map_status), .map_fault(map_fault), .write_fault(write_fault),
      .error_count(error_count), .checked_count(checked_count), .pending(pending),
      .map_fault_count(map_fault_count), .write_fault_count(write_fault_count)
   );

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h80200003;
      return s >> 1;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits       = {bits[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return bits;
   endfunction

   task automatic next_cycle();
      @(posedge clk_a);
      #1;
   endtask

   task automatic write_l0(input vmem0_addr_t addr, input vmem0_data_t data);
      vmem0_wr      = 1'b1;
      vmem0_wr_addr = addr;
      vmem0_wr_data = data;
      l0_loaded[addr] = data;
      next_cycle();
      vmem0_wr = 1'b0;
   endtask

   task automatic write_l1(input vmem1_addr_t addr, input vmem1_word_t word);
      vmem1_wr      = 1'b1;
      vmem1_wr_addr = addr;
      vmem1_wr_data = word;
      next_cycle();
      vmem1_wr = 1'b0;
   endtask

   task automatic issue_lookup(input vma_t v, input logic wr);
      lookup_req   = 1'b1;
      vma          = v;
      write_access = wr;
      next_cycle();
      lookup_req = 1'b0;
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (pending != 0 && n < 10)
      begin
         next_cycle();
         n++;
      end
      if (pending != 0)
      begin
         $display("%0d lookups still unanswered at %0t ns", pending, $time);
         local_errors++;
      end
   endtask

   task automatic start_test();
      errors_at_start  = error_count + local_errors;
      checked_at_start = checked_count;
      mf_at_start      = map_fault_count;
      wf_at_start      = write_fault_count;
   endtask

   task automatic finish_test(input int num, input string name);
      $display("test %0d %s: %0d lookups, %0d map faults, %0d write faults, %0d errors",
               num, name, checked_count - checked_at_start, map_fault_count - mf_at_start,
               write_fault_count - wf_at_start, error_count + local_errors - errors_at_start);
   endtask

   always @(posedge clk_a)
   begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES)
      begin
         $display("run stopped after %0d cycles without finishing", cycles);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial
   begin
      lookup_req    = 1'b0;
      vma           = '0;
      write_access  = 1'b0;
      vmem0_wr      = 1'b0;
      vmem0_wr_addr = '0;
      vmem0_wr_data = '0;
      vmem1_wr      = 1'b0;
      vmem1_wr_addr = '0;
      vmem1_wr_data = '0;
      @(negedge reset);
      next_cycle();

      start_test();
      repeat (20) next_cycle();   // checker flags any stray output
      finish_test(1, "idle after reset");

      start_test();
      for (int i = 0; i < `VMEM0_DEPTH; i++)
      begin
         vmem0_wr      = 1'b1;
         vmem0_wr_addr = vmem0_addr_t'(i);
         vmem0_wr_data = vmem0_data_t'(take_bits(5));
         l0_loaded[i]  = vmem0_wr_data;
         vmem1_wr      = (i < `VMEM1_DEPTH);   // both ports in the same cycle
         vmem1_wr_addr = vmem1_addr_t'(i);
         vmem1_wr_data = {2'b11, 22'(take_bits(22))};
         next_cycle();
      end
      vmem0_wr = 1'b0;
      vmem1_wr = 1'b0;
      repeat (4) next_cycle();
      for (int i = 0; i < 64; i++)
      begin
         issue_lookup(vma_t'(take_bits(24)), 1'b0);
         wait_drained();
      end
      finish_test(2, "single read lookups");

      start_test();
      for (int i = 0; i < 32; i++)
      begin
         lookup_req   = 1'b1;
         vma          = vma_t'(take_bits(24));
         write_access = 1'(take_bits(1));
         next_cycle();
      end
      lookup_req = 1'b0;
      wait_drained();
      finish_test(3, "back-to-back lookups");

      // block 7 becomes write protected
      start_test();
      regions[0] = vmem0_addr_t'(take_bits(11));
      write_l0(regions[0], 5'd7);
      for (int p = 0; p < 32; p++)
         write_l1({5'd7, 5'(p)}, {2'b10, 22'(take_bits(22))});
      repeat (4) next_cycle();
      for (int i = 0; i < 16; i++)
      begin
         issue_lookup({regions[0], 13'(take_bits(13))}, i[0]);
         wait_drained();
      end
      finish_test(4, "write-protected pages");

      // block 12 becomes unmapped
      start_test();
      regions[0] = vmem0_addr_t'(take_bits(11));
      write_l0(regions[0], 5'd12);
      for (int p = 0; p < 32; p++)
         write_l1({5'd12, 5'(p)}, {1'b0, 23'(take_bits(23))});
      repeat (4) next_cycle();
      for (int i = 0; i < 16; i++)
      begin
         issue_lookup({regions[0], 13'(take_bits(13))}, i[0]);
         wait_drained();
      end
      finish_test(5, "unmapped pages");

      start_test();
      for (int i = 0; i < 16; i++)
      begin
         regions[i] = vmem0_addr_t'(take_bits(11));
         write_l0(regions[i], ~l0_loaded[regions[i]]);   // always a different block
      end
      repeat (4) next_cycle();
      for (int i = 0; i < 16; i++)
      begin
         issue_lookup({regions[i], 13'(take_bits(13))}, 1'(take_bits(1)));
         wait_drained();
      end
      finish_test(6, "remapped level-0 entries");

      total_errors = error_count + local_errors;
      $display("6 tests, %0d lookups checked, %0d errors", checked_count, total_errors);
      if (total_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

/* vmem_map.f */
+incdir+verilog
verilog/vmem_pkg.sv
verilog/vmem0_ram.sv
verilog/vmem1_ram.sv
verilog/map_stage0.sv
verilog/map_stage1.sv
verilog/map_stage2.sv
verilog/vmem_map.sv
tb/tb_clock.sv
tb/vmem_map_checker.sv
tb/vmem_map_tb.sv
